// ==== include/conv_settings.svh ====
////////////////////////////////////////////////////////////
// widths, depths and constants of the 3x3 conv engine
// stream word layout, accumulator size, quantization
////////////////////////////////////////////////////////////
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// stream word and lanes
`define CONV_WORD_W       32
`define CONV_PIX_W        8
`define CONV_LANES        4

// accumulator and frame size
`define CONV_ACC_W        28
`define CONV_FLEN_W       6
`define CONV_MAX_FLEN     32
`define CONV_KERNEL       3
`define CONV_TAPS         9
`define CONV_FEAT_DEPTH   256

// multiplier depth and output quantization
`define CONV_MULT_STAGES  8
`define CONV_QUANT_SHIFT  6
`define CONV_SAT_MAX      127

`endif

// ==== logic/conv_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types of the conv engine
// pixel and accumulator values, stream word view, phases
////////////////////////////////////////////////////////////
`default_nettype none
`include "conv_settings.svh"

package conv_pkg;

  // signed feature, weight or bias
  typedef logic signed [`CONV_PIX_W-1:0] pixel_t;

  // signed tap accumulator
  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

  // one stream word, raw or as four lanes (lane 0 in low byte)
  typedef union packed {
    logic [`CONV_WORD_W-1:0]   raw;
    pixel_t [`CONV_LANES-1:0]  lane;
  } stream_word_u;

  typedef enum logic [2:0] {LD_IDLE, LD_FEATURE, LD_BIAS, LD_WEIGHT, LD_HOLD} load_phase_e;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_FILL, SEQ_ISSUE, SEQ_WAIT} seq_phase_e;

endpackage

`default_nettype wire

// ==== logic/feature_buffer.sv ====
////////////////////////////////////////////////////////////
// feature word memory
// one write port, one registered read port
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module feature_buffer (
  input  logic                                 clk,
  input  logic                                 wr_en,
  input  logic [$clog2(`CONV_FEAT_DEPTH)-1:0]  wr_addr,
  input  logic [`CONV_WORD_W-1:0]              wr_data,
  input  logic                                 rd_en,
  input  logic [$clog2(`CONV_FEAT_DEPTH)-1:0]  rd_addr,
  output logic [`CONV_WORD_W-1:0]              rd_data
);

  // stands in for the feature sram
  logic [`CONV_WORD_W-1:0] mem [`CONV_FEAT_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    // data one cycle after rd_en
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== logic/stream_loader.sv ====
////////////////////////////////////////////////////////////
// input stream receiver
// writes feature words to the buffer, then latches the
// bias word and the three weight words
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module stream_loader
  import conv_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rstn,
  input  logic                                 start,
  input  logic [`CONV_FLEN_W-1:0]              flen,
  input  logic                                 in_valid,
  output logic                                 in_ready,
  input  logic [`CONV_WORD_W-1:0]              in_data,
  input  logic                                 done,
  output logic                                 wr_en,
  output logic [$clog2(`CONV_FEAT_DEPTH)-1:0]  wr_addr,
  output logic [`CONV_WORD_W-1:0]              wr_data,
  output logic                                 frame_loaded,
  output logic [`CONV_FLEN_W-1:0]              frame_flen,
  output pixel_t [`CONV_TAPS-1:0]              weights,
  output pixel_t                               bias
);

  localparam int ADDR_W    = $clog2(`CONV_FEAT_DEPTH);
  localparam int WGT_WORDS = (`CONV_TAPS + `CONV_LANES - 1) / `CONV_LANES;

  load_phase_e               phase;
  stream_word_u              in_word;
  logic                      accept;
  logic [ADDR_W-1:0]         word_cnt;
  logic [1:0]                wgt_cnt;
  logic [2*`CONV_FLEN_W-1:0] area;
  logic [ADDR_W:0]           frame_words;
  logic                      feat_last;

  assign in_word.raw = in_data;
  assign in_ready    = phase inside {LD_FEATURE, LD_BIAS, LD_WEIGHT};
  assign accept      = in_valid && in_ready;

  // flen*flen/4 feature words per frame
  assign area        = frame_flen * frame_flen;
  assign frame_words = (ADDR_W + 1)'(area >> 2);
  assign feat_last   = ({1'b0, word_cnt} + 1'b1) == frame_words;

  // features go straight into consecutive buffer words
  assign wr_en   = accept && (phase == LD_FEATURE);
  assign wr_addr = word_cnt;
  assign wr_data = in_data;

  ////////////////////////////////////////////////////////////
  // phase control
  always_ff @(posedge clk) begin
    if (!rstn) begin
      phase        <= LD_IDLE;
      word_cnt     <= '0;
      wgt_cnt      <= '0;
      frame_loaded <= 1'b0;
    end else begin
      // pulse the cycle after the last weight word
      frame_loaded <= accept && (phase == LD_WEIGHT) && (wgt_cnt == 2'(WGT_WORDS - 1));
      case (phase)
        LD_IDLE: begin
          if (start) begin
            phase    <= LD_FEATURE;
            word_cnt <= '0;
          end
        end
        LD_FEATURE: begin
          if (accept) begin
            word_cnt <= word_cnt + 1'b1;
            if (feat_last) phase <= LD_BIAS;
          end
        end
        LD_BIAS: begin
          if (accept) begin
            phase   <= LD_WEIGHT;
            wgt_cnt <= '0;
          end
        end
        LD_WEIGHT: begin
          if (accept) begin
            wgt_cnt <= wgt_cnt + 1'b1;
            if (wgt_cnt == 2'(WGT_WORDS - 1)) phase <= LD_HOLD;
          end
        end
        // parked until the packer reports the frame out
        LD_HOLD: begin
          if (done) phase <= LD_IDLE;
        end
        default: phase <= LD_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // frame size, bias, weights
  always_ff @(posedge clk) begin
    if ((phase == LD_IDLE) && start) frame_flen <= flen;
    if (accept && (phase == LD_BIAS)) bias <= in_word.lane[0];
    // row-major weights across lanes, spare lanes of last word dropped
    if (accept && (phase == LD_WEIGHT)) begin
      for (int l = 0; l < `CONV_LANES; l++) begin
        if (wgt_cnt * `CONV_LANES + l < `CONV_TAPS) begin
          weights[wgt_cnt * `CONV_LANES + l] <= in_word.lane[l];
        end
      end
    end
  end

  // input stays closed from frame load until done, and from done until next start
  a_hold_closed: assert property (@(posedge clk) disable iff (!rstn)
    frame_loaded |-> (!accept until done));
  a_idle_closed: assert property (@(posedge clk) disable iff (!rstn)
    done |=> (!accept until start));

endmodule

`default_nettype wire

// ==== logic/window_sequencer.sv ====
////////////////////////////////////////////////////////////
// 3x3 window walker
// three zero-padded line registers filled from the buffer,
// nine taps per output pixel sent to the multiplier
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module window_sequencer
  import conv_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rstn,
  input  logic                                 frame_loaded,
  input  logic [`CONV_FLEN_W-1:0]              frame_flen,
  input  pixel_t [`CONV_TAPS-1:0]              weights,
  output logic                                 rd_en,
  output logic [$clog2(`CONV_FEAT_DEPTH)-1:0]  rd_addr,
  input  logic [`CONV_WORD_W-1:0]              rd_data,
  output logic                                 tap_valid,
  output pixel_t                               tap_feat,
  output pixel_t                               tap_weight,
  output logic                                 tap_first,
  output logic                                 tap_last,
  output logic                                 tap_frame_end,
  input  logic                                 acc_valid,
  input  logic                                 acc_ready
);

  localparam int LINE_W = `CONV_MAX_FLEN + 2;
  localparam int ADDR_W = $clog2(`CONV_FEAT_DEPTH);
  localparam int ROW_W  = `CONV_FLEN_W;
  localparam int WPR_W  = `CONV_FLEN_W - 2;

  seq_phase_e               phase;
  // line 0 on top, one zero pad pixel at each end
  pixel_t [LINE_W-1:0]      lines [`CONV_KERNEL];
  stream_word_u             feat_word;
  logic [ROW_W-1:0]         fill_row;
  logic [ROW_W-1:0]         col;
  logic [WPR_W-1:0]         words_per_row;
  logic [WPR_W-1:0]         rd_cnt;
  logic [WPR_W-1:0]         pend_col;
  logic [ADDR_W-1:0]        rd_ptr;
  logic                     rd_pend;
  logic [1:0]               kx;
  logic [1:0]               ky;
  logic [3:0]               tap_idx;
  logic                     got_acc;
  logic                     row_valid;
  logic                     fill_done;
  logic                     col_last;
  logic                     pix_done;
  logic                     frame_start;
  logic                     start_fill;

  assign feat_word.raw = rd_data;
  assign words_per_row = frame_flen[ROW_W-1:2];
  assign frame_start   = (phase == SEQ_IDLE) && frame_loaded;

  // rows past the bottom edge stay zero
  assign row_valid = fill_row < frame_flen;
  assign rd_en     = (phase == SEQ_FILL) && row_valid && (rd_cnt != words_per_row);
  assign rd_addr   = rd_ptr;
  assign fill_done = (phase == SEQ_FILL) && !rd_pend && (!row_valid || rd_cnt == words_per_row);

  // next pixel only once the last result is back and the packer has room
  assign col_last   = col == frame_flen - 1'b1;
  assign pix_done   = (phase == SEQ_WAIT) && got_acc && acc_ready;
  assign start_fill = (fill_done && (fill_row == '0)) ||
                      (pix_done && col_last && (fill_row != frame_flen));

  ////////////////////////////////////////////////////////////
  // tap outputs
  assign tap_idx       = 4'(ky) * 4'(`CONV_KERNEL) + 4'(kx);
  assign tap_valid     = phase == SEQ_ISSUE;
  assign tap_feat      = lines[ky][col + kx];
  assign tap_weight    = weights[tap_idx];
  assign tap_first     = tap_valid && (ky == 2'd0) && (kx == 2'd0);
  assign tap_last      = tap_valid && (ky == 2'(`CONV_KERNEL - 1)) && (kx == 2'(`CONV_KERNEL - 1));
  // output row is fill_row-1, so the last row shows fill_row == flen
  assign tap_frame_end = tap_valid && (fill_row == frame_flen) && col_last;

  ////////////////////////////////////////////////////////////
  // walker fsm
  always_ff @(posedge clk) begin
    if (!rstn) begin
      phase    <= SEQ_IDLE;
      fill_row <= '0;
      col      <= '0;
      rd_cnt   <= '0;
      rd_ptr   <= '0;
      rd_pend  <= 1'b0;
      kx       <= '0;
      ky       <= '0;
      got_acc  <= 1'b0;
    end else begin
      rd_pend <= rd_en;
      if (rd_en) begin
        rd_cnt <= rd_cnt + 1'b1;
        rd_ptr <= rd_ptr + 1'b1;
      end
      case (phase)
        SEQ_IDLE: begin
          if (frame_loaded) begin
            phase    <= SEQ_FILL;
            fill_row <= '0;
            rd_cnt   <= '0;
            rd_ptr   <= '0;
          end
        end
        SEQ_FILL: begin
          if (fill_done) begin
            rd_cnt <= '0;
            // row 0 only primes the bottom line, fetch row 1 too
            if (fill_row == '0) begin
              fill_row <= 1'b1;
            end else begin
              phase <= SEQ_ISSUE;
              col   <= '0;
            end
          end
        end
        SEQ_ISSUE: begin
          if (kx == 2'(`CONV_KERNEL - 1)) begin
            kx <= '0;
            if (ky == 2'(`CONV_KERNEL - 1)) begin
              ky      <= '0;
              phase   <= SEQ_WAIT;
              got_acc <= 1'b0;
            end else begin
              ky <= ky + 1'b1;
            end
          end else begin
            kx <= kx + 1'b1;
          end
        end
        SEQ_WAIT: begin
          if (acc_valid) got_acc <= 1'b1;
          if (pix_done) begin
            if (!col_last) begin
              col   <= col + 1'b1;
              phase <= SEQ_ISSUE;
            end else if (fill_row != frame_flen) begin
              fill_row <= fill_row + 1'b1;
              phase    <= SEQ_FILL;
            end else begin
              phase <= SEQ_IDLE;
            end
          end
        end
        default: phase <= SEQ_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // line registers
  always_ff @(posedge clk) begin
    pend_col <= rd_cnt;
    if (frame_start) begin
      lines <= '{default: '0};
    end else if (start_fill) begin
      // shift up, bottom line cleared for the new row
      lines[0] <= lines[1];
      lines[1] <= lines[2];
      lines[2] <= '0;
    end else if (rd_pend) begin
      for (int l = 0; l < `CONV_LANES; l++) begin
        lines[2][1 + `CONV_LANES * pend_col + l] <= feat_word.lane[l];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/mac_pipeline.sv ====
////////////////////////////////////////////////////////////
// eight-stage sign-magnitude multiplier
// partial products reduced low half then high half per
// level, sign restored last, then nine-tap accumulate
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module mac_pipeline
  import conv_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  logic    tap_valid,
  input  pixel_t  tap_feat,
  input  pixel_t  tap_weight,
  input  logic    tap_first,
  input  logic    tap_last,
  input  logic    tap_frame_end,
  output logic    acc_valid,
  output acc_t    acc_sum,
  output logic    acc_frame_end
);

  localparam int STAGES = `CONV_MULT_STAGES;
  localparam int PW     = `CONV_PIX_W;

  logic [PW-1:0]        a_mag;
  logic [PW-1:0]        b_mag;
  logic [PW-1:0]        pp_q [PW];
  // level 1, pairs of partial products
  logic [5:0]           lo1_q [4];
  logic [2:0]           xh1_q [4];
  logic [3:0]           yh1_q [4];
  logic [9:0]           s1_q [4];
  // level 2, quads
  logic [7:0]           lo2_q [2];
  logic [2:0]           xh2_q [2];
  logic [4:0]           yh2_q [2];
  logic [11:0]          s2_q [2];
  // level 3, full magnitude
  logic [9:0]           lo3_q;
  logic [2:0]           xh3_q;
  logic [6:0]           yh3_q;
  logic [15:0]          mag_q;
  logic signed [15:0]   prod_q;
  // tags beside the data
  logic [STAGES-2:0]    sign_sr;
  logic [STAGES-1:0]    vld_sr;
  logic [STAGES-1:0]    first_sr;
  logic [STAGES-1:0]    last_sr;
  logic [STAGES-1:0]    end_sr;
  acc_t                 acc_q;
  logic                 pix_open;

  assign a_mag   = tap_feat[PW-1] ? -tap_feat : tap_feat;
  assign b_mag   = tap_weight[PW-1] ? -tap_weight : tap_weight;
  assign acc_sum = acc_q;

  ////////////////////////////////////////////////////////////
  // datapath stages
  always_ff @(posedge clk) begin
    // s1 partial products
    for (int i = 0; i < PW; i++) begin
      pp_q[i] <= b_mag[i] ? a_mag : '0;
    end
    // s2 low bits of pp[2i] + pp[2i+1]<<1
    for (int i = 0; i < 4; i++) begin
      lo1_q[i] <= pp_q[2*i][4:0] + {pp_q[2*i+1][3:0], 1'b0};
      xh1_q[i] <= pp_q[2*i][7:5];
      yh1_q[i] <= pp_q[2*i+1][7:4];
    end
    // s3 high bits plus carry
    for (int i = 0; i < 4; i++) begin
      s1_q[i] <= {5'(xh1_q[i] + yh1_q[i] + lo1_q[i][5]), lo1_q[i][4:0]};
    end
    // s4 low bits, second pair shifted by 2
    for (int i = 0; i < 2; i++) begin
      lo2_q[i] <= s1_q[2*i][6:0] + {s1_q[2*i+1][4:0], 2'b00};
      xh2_q[i] <= s1_q[2*i][9:7];
      yh2_q[i] <= s1_q[2*i+1][9:5];
    end
    // s5
    for (int i = 0; i < 2; i++) begin
      s2_q[i] <= {5'(xh2_q[i] + yh2_q[i] + lo2_q[i][7]), lo2_q[i][6:0]};
    end
    // s6 low bits, upper quad shifted by 4
    lo3_q <= s2_q[0][8:0] + {s2_q[1][4:0], 4'b0000};
    xh3_q <= s2_q[0][11:9];
    yh3_q <= s2_q[1][11:5];
    // s7
    mag_q <= {7'(xh3_q + yh3_q + lo3_q[9]), lo3_q[8:0]};
    // s8 sign back on, |product| never above 2^14
    prod_q <= sign_sr[STAGES-2] ? -$signed(mag_q) : $signed(mag_q);

    sign_sr  <= {sign_sr[STAGES-3:0], tap_feat[PW-1] ^ tap_weight[PW-1]};
    first_sr <= {first_sr[STAGES-2:0], tap_first};
    last_sr  <= {last_sr[STAGES-2:0], tap_last};
    end_sr   <= {end_sr[STAGES-2:0], tap_frame_end};

    // accumulate, restart on the first tap of a pixel
    if (vld_sr[STAGES-1]) begin
      acc_q         <= (first_sr[STAGES-1] ? acc_t'(0) : acc_q) + acc_t'(prod_q);
      acc_frame_end <= end_sr[STAGES-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // valid chain and pixel tracking
  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_sr    <= '0;
      acc_valid <= 1'b0;
      pix_open  <= 1'b0;
    end else begin
      vld_sr    <= {vld_sr[STAGES-2:0], tap_valid};
      acc_valid <= vld_sr[STAGES-1] && last_sr[STAGES-1];
      if (tap_valid && tap_last) begin
        pix_open <= 1'b0;
      end else if (tap_valid && tap_first) begin
        pix_open <= 1'b1;
      end
    end
  end

  // a new pixel never starts inside another one
  a_first_closed: assert property (@(posedge clk) disable iff (!rstn)
    (tap_valid && tap_first) |-> !pix_open);

endmodule

`default_nettype wire

// ==== logic/result_packer.sv ====
////////////////////////////////////////////////////////////
// output packer
// bias add, rectify, saturate to 7 bits, four lanes per
// word, output stream with last flag and done pulse
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module result_packer
  import conv_pkg::*;
(
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     acc_valid,
  input  acc_t                     acc_sum,
  input  logic                     acc_frame_end,
  input  pixel_t                   bias,
  output logic                     acc_ready,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic [`CONV_WORD_W-1:0]  out_data,
  output logic                     out_last,
  output logic                     done
);

  localparam int LANE_W = $clog2(`CONV_LANES);
  localparam int QS     = `CONV_QUANT_SHIFT;
  // lowest bit that forces saturation, 13
  localparam int SAT_LO = QS + `CONV_PIX_W - 1;

  acc_t               biased;
  pixel_t             res;
  logic [LANE_W-1:0]  lane;
  logic               take;
  stream_word_u       word_q;

  assign biased   = acc_sum + (acc_t'(bias) <<< QS);
  assign take     = acc_valid && acc_ready;
  assign out_data = word_q.raw;

  // relu then clamp, bits 12..6 when in range
  always_comb begin
    if (biased[`CONV_ACC_W-1]) begin
      res = '0;
    end else if (|biased[`CONV_ACC_W-2:SAT_LO]) begin
      res = pixel_t'(`CONV_SAT_MAX);
    end else begin
      res = pixel_t'(biased[SAT_LO-1:QS]);
    end
  end

  always_ff @(posedge clk) begin
    if (take) word_q.lane[lane] <= res;
  end

  ////////////////////////////////////////////////////////////
  // lane count and output handshake
  always_ff @(posedge clk) begin
    if (!rstn) begin
      lane      <= '0;
      acc_ready <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= out_valid && out_ready && out_last;
      if (take) lane <= lane + 1'b1;
      if (take && (lane == LANE_W'(`CONV_LANES - 1))) begin
        // word full, stop results until it leaves
        out_valid <= 1'b1;
        out_last  <= acc_frame_end;
        acc_ready <= 1'b0;
      end else if (out_valid && out_ready) begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
        acc_ready <= 1'b1;
      end else if (!out_valid) begin
        acc_ready <= 1'b1;
      end
    end
  end

  // word held steady under back-pressure
  a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
    (out_valid && !out_ready) |=> $stable(out_data));

endmodule

`default_nettype wire

// ==== logic/conv_engine.sv ====
////////////////////////////////////////////////////////////
// conv engine top level
// loader, feature memory, window walker, multiplier, packer
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module conv_engine
  import conv_pkg::*;
(
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start,
  input  logic [`CONV_FLEN_W-1:0]     flen,
  input  logic                        in_valid,
  output logic                        in_ready,
  input  logic [`CONV_WORD_W-1:0]     in_data,
  output logic                        out_valid,
  input  logic                        out_ready,
  output logic [`CONV_WORD_W-1:0]     out_data,
  output logic                        out_last,
  output logic                        done
);

  // loader to buffer
  logic                                 wr_en;
  logic [$clog2(`CONV_FEAT_DEPTH)-1:0]  wr_addr;
  logic [`CONV_WORD_W-1:0]              wr_data;
  // loader to sequencer and packer
  logic                                 frame_loaded;
  logic [`CONV_FLEN_W-1:0]              frame_flen;
  pixel_t [`CONV_TAPS-1:0]              weights;
  pixel_t                               bias;
  // sequencer to buffer
  logic                                 rd_en;
  logic [$clog2(`CONV_FEAT_DEPTH)-1:0]  rd_addr;
  logic [`CONV_WORD_W-1:0]              rd_data;
  // tap stream
  logic                                 tap_valid;
  pixel_t                               tap_feat;
  pixel_t                               tap_weight;
  logic                                 tap_first;
  logic                                 tap_last;
  logic                                 tap_frame_end;
  // pixel results
  logic                                 acc_valid;
  acc_t                                 acc_sum;
  logic                                 acc_frame_end;
  logic                                 acc_ready;

  stream_loader u_loader (
    .clk(clk), .rstn(rstn), .start(start), .flen(flen),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data), .done(done),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .frame_loaded(frame_loaded), .frame_flen(frame_flen),
    .weights(weights), .bias(bias)
  );

  feature_buffer u_buffer (
    .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  window_sequencer u_sequencer (
    .clk(clk), .rstn(rstn), .frame_loaded(frame_loaded), .frame_flen(frame_flen),
    .weights(weights), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
    .tap_valid(tap_valid), .tap_feat(tap_feat), .tap_weight(tap_weight),
    .tap_first(tap_first), .tap_last(tap_last), .tap_frame_end(tap_frame_end),
    .acc_valid(acc_valid), .acc_ready(acc_ready)
  );

  mac_pipeline u_mac (
    .clk(clk), .rstn(rstn), .tap_valid(tap_valid), .tap_feat(tap_feat),
    .tap_weight(tap_weight), .tap_first(tap_first), .tap_last(tap_last),
    .tap_frame_end(tap_frame_end), .acc_valid(acc_valid), .acc_sum(acc_sum),
    .acc_frame_end(acc_frame_end)
  );

  result_packer u_packer (
    .clk(clk), .rstn(rstn), .acc_valid(acc_valid), .acc_sum(acc_sum),
    .acc_frame_end(acc_frame_end), .bias(bias), .acc_ready(acc_ready),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
    .out_last(out_last), .done(done)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
////////////////////////////////////////////////////////////
// testbench clock and reset
// 4 ns clock, active low reset over the first edges
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_PERIOD_NS = 2,
  parameter int RESET_CYCLES   = 3
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // released just after an edge, like the other drives
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/conv_engine_tb.sv ====
////////////////////////////////////////////////////////////
// testbench for the conv engine
// case table, reference model of the padded 3x3 conv,
// input and output stream drivers, value checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module conv_engine_tb;

  localparam int WAIT_LIMIT  = 1000;
  localparam int FRAME_LIMIT = 200000;
  localparam int NUM_CASES   = 9;
  localparam int MAX_PIX     = `CONV_MAX_FLEN * `CONV_MAX_FLEN;

  // feature kinds
  localparam int FEAT_RAND = 0;
  localparam int FEAT_POS  = 1;
  // weight kinds
  localparam int WGT_IDENT = 0;
  localparam int WGT_SMALL = 1;
  localparam int WGT_RAND  = 2;
  localparam int WGT_BIG   = 3;
  localparam int WGT_NEG   = 4;
  // bias field value that asks for a random bias
  localparam int BIAS_RAND = 1000;

  typedef struct {
    int flen;
    int feat_kind;
    int wgt_kind;
    int bias;
    int stall_pct;
  } case_t;

  ////////////////////////////////////////////////////////////
  // case table, frames run back to back in this order
  case_t cases [NUM_CASES] = '{
    '{4,  FEAT_RAND, WGT_IDENT, 0,         0},
    '{4,  FEAT_RAND, WGT_SMALL, BIAS_RAND, 0},
    '{8,  FEAT_RAND, WGT_SMALL, BIAS_RAND, 0},
    '{16, FEAT_RAND, WGT_RAND,  BIAS_RAND, 0},
    '{8,  FEAT_POS,  WGT_BIG,   100,       0},
    '{8,  FEAT_POS,  WGT_NEG,   -100,      0},
    '{8,  FEAT_RAND, WGT_SMALL, BIAS_RAND, 50},
    '{16, FEAT_RAND, WGT_SMALL, BIAS_RAND, 30},
    '{4,  FEAT_RAND, WGT_SMALL, -5,        70}
  };

  logic                     clk;
  logic                     rstn;
  logic                     start;
  logic [`CONV_FLEN_W-1:0]  flen;
  logic                     in_valid;
  logic                     in_ready;
  logic [`CONV_WORD_W-1:0]  in_data;
  logic                     out_valid;
  logic                     out_ready;
  logic [`CONV_WORD_W-1:0]  out_data;
  logic                     out_last;
  logic                     done;

  // current frame as seen by the model
  int           feat_pix [MAX_PIX];
  int           wgt [`CONV_TAPS];
  int           bias_val;
  int           cur_flen;
  int           errors;
  int           done_count;

  tb_clock #(.HALF_PERIOD_NS(2), .RESET_CYCLES(3)) u_clock (.clk(clk), .rstn(rstn));

  conv_engine DUT (
    .clk(clk), .rstn(rstn), .start(start), .flen(flen),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
    .out_last(out_last), .done(done)
  );

  // every done pulse, sampled mid-cycle
  always @(negedge clk) begin
    if (rstn && done) done_count++;
  end

  ////////////////////////////////////////////////////////////
  // failure reporting
  task automatic abort_run(input string why);
    errors++;
    $display("ERROR: %s at %0t", why, $time);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("FAIL %s: got 0x%h expected 0x%h at %0t", name, got, expected, $time);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  function automatic int rand_between(int lo, int hi);
    return lo + int'($urandom_range(hi - lo));
  endfunction

  // padded 3x3 sum, bias times 64, relu and 7-bit clamp
  function automatic int pixel_result(int y, int x);
    int sum;
    int yy;
    int xx;
    sum = bias_val * (1 << `CONV_QUANT_SHIFT);
    for (int ky = 0; ky < `CONV_KERNEL; ky++) begin
      for (int kx = 0; kx < `CONV_KERNEL; kx++) begin
        yy = y + ky - 1;
        xx = x + kx - 1;
        if (yy >= 0 && yy < cur_flen && xx >= 0 && xx < cur_flen) begin
          sum += wgt[ky * `CONV_KERNEL + kx] * feat_pix[yy * cur_flen + xx];
        end
      end
    end
    if (sum < 0) return 0;
    // anything with a bit above bit 12
    if (sum >= ((`CONV_SAT_MAX + 1) << `CONV_QUANT_SHIFT)) return `CONV_SAT_MAX;
    return sum >> `CONV_QUANT_SHIFT;
  endfunction

  // raster order, pixel 4k+l goes to lane l of word k
  function automatic logic [31:0] expected_word(int k);
    logic [31:0] w;
    int p;
    w = '0;
    for (int l = 0; l < `CONV_LANES; l++) begin
      p = k * `CONV_LANES + l;
      w[8*l +: 8] = 8'(pixel_result(p / cur_flen, p % cur_flen));
    end
    return w;
  endfunction

  function automatic logic [31:0] lanes_word(int l0, int l1, int l2, int l3);
    return {8'(l3), 8'(l2), 8'(l1), 8'(l0)};
  endfunction

  task automatic make_frame(input case_t c);
    cur_flen = c.flen;
    for (int i = 0; i < c.flen * c.flen; i++) begin
      if (c.feat_kind == FEAT_POS) begin
        feat_pix[i] = rand_between(64, 127);
      end else begin
        feat_pix[i] = rand_between(-128, 127);
      end
    end
    for (int t = 0; t < `CONV_TAPS; t++) begin
      case (c.wgt_kind)
        WGT_IDENT: wgt[t] = (t == 4) ? 64 : 0;
        WGT_SMALL: wgt[t] = rand_between(-4, 4);
        WGT_BIG:   wgt[t] = 127;
        WGT_NEG:   wgt[t] = rand_between(-128, -1);
        default:   wgt[t] = rand_between(-128, 127);
      endcase
    end
    bias_val = (c.bias == BIAS_RAND) ? rand_between(-32, 31) : c.bias;
  endtask

  ////////////////////////////////////////////////////////////
  // stream drivers, all drives 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_word(input logic [31:0] data);
    int waited;
    waited = 0;
    in_valid = 1'b1;
    in_data  = data;
    while (!in_ready) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for in_ready");
    end
    if (out_valid || done) abort_run("output activity while the frame loads");
    next_cycle();
    in_valid = 1'b0;
  endtask

  task automatic load_frame();
    int base;
    logic [31:0] noisy;
    start = 1'b1;
    flen  = `CONV_FLEN_W'(cur_flen);
    next_cycle();
    start = 1'b0;
    for (int k = 0; k < cur_flen * cur_flen / `CONV_LANES; k++) begin
      base = k * `CONV_LANES;
      send_word(lanes_word(feat_pix[base], feat_pix[base + 1],
                           feat_pix[base + 2], feat_pix[base + 3]));
    end
    // bias in lane 0, the rest is noise
    noisy = $urandom();
    noisy[7:0] = 8'(bias_val);
    send_word(noisy);
    send_word(lanes_word(wgt[0], wgt[1], wgt[2], wgt[3]));
    send_word(lanes_word(wgt[4], wgt[5], wgt[6], wgt[7]));
    // w8 in lane 0, spare lanes ignored by the DUT
    noisy = $urandom();
    noisy[7:0] = 8'(wgt[8]);
    send_word(noisy);
  endtask

  // takes every output word with random stalls, then waits for done
  task automatic collect_frame(input int stall_pct);
    int nwords;
    int got;
    int waited;
    logic stalled;
    logic [31:0] held;
    nwords  = cur_flen * cur_flen / `CONV_LANES;
    got     = 0;
    waited  = 0;
    stalled = 1'b0;
    held    = '0;
    while (got < nwords) begin
      // a stalled word stays put
      if (stalled) begin
        check_value("out_valid", out_valid, 1);
        check_value("out_data", out_data, held);
      end
      if (done) abort_run("done raised before the last word");
      out_ready = int'($urandom_range(99)) >= stall_pct;
      stalled   = out_valid && !out_ready;
      held      = out_data;
      if (out_valid && out_ready) begin
        check_value("out_data", out_data, expected_word(got));
        check_value("out_last", out_last, got == nwords - 1);
        got++;
      end
      next_cycle();
      waited++;
      if (waited > FRAME_LIMIT) abort_run("timeout waiting for output words");
    end
    out_ready = 1'b0;
    waited = 0;
    while (!done) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for done");
    end
    next_cycle();
    // single cycle pulse, and nothing more on the output
    check_value("done", done, 0);
    check_value("out_valid", out_valid, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  initial begin
    int waited;
    start      = 1'b0;
    flen       = '0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b0;
    errors     = 0;
    done_count = 0;
    void'($urandom(32'h54ea8206));
    waited     = 0;
    while (rstn !== 1'b1) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) abort_run("reset was never released");
    end
    next_cycle();
    // idle state straight out of reset
    check_value("in_ready", in_ready, 0);
    check_value("out_valid", out_valid, 0);
    check_value("out_last", out_last, 0);
    check_value("done", done, 0);
    for (int i = 0; i < NUM_CASES; i++) begin
      make_frame(cases[i]);
      load_frame();
      collect_frame(cases[i].stall_pct);
      check_value("done_count", done_count, i + 1);
    end
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
logic/conv_pkg.sv
logic/feature_buffer.sv
logic/stream_loader.sv
logic/window_sequencer.sv
logic/mac_pipeline.sv
logic/result_packer.sv
logic/conv_engine.sv
sim/tb_clock.sv
sim/conv_engine_tb.sv
